// File: source/hash_loop_pkg.sv
package hash_loop_pkg;

  // ==========================================================================
  // defaults for the top level parameters
  // ==========================================================================
  // line address width for a 2 MB scratchpad of 64-byte lines
  parameter int ADDR_WIDTH_DEFAULT = 15;
  parameter int ITER_LOG2_DEFAULT = 19;
  parameter int MULT_LATENCY_DEFAULT = 1;

  // ==========================================================================
  // data types
  // ==========================================================================
  typedef logic [63:0] word_t;

  // hi sits in bits [127:64]
  typedef struct packed {
    word_t hi;
    word_t lo;
  } block_t;

  typedef logic [511:0] line_t;

  // byte address bits [5:4]
  typedef logic [1:0] lane_idx_t;

  // logical lanes of one line, cx is logical lane 0
  typedef struct packed {
    block_t cx;
    block_t chk1;
    block_t chk2;
    block_t chk3;
  } lane_set_t;

  // chaining state in and out of a run
  typedef struct packed {
    block_t a;
    block_t bx0;
    block_t bx1;
  } loop_state_t;

  typedef enum logic [2:0] {
    phase_idle,
    phase_read1,
    phase_cipher,
    phase_write1,
    phase_read2,
    phase_step,
    phase_mul,
    phase_write2
  } phase_t;

endpackage

// File: source/loop_sequencer.sv
`timescale 1ns/1ps

module loop_sequencer #(
  parameter int iter_log2 = hash_loop_pkg::ITER_LOG2_DEFAULT,
  parameter int mult_latency = hash_loop_pkg::MULT_LATENCY_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  ctrl_start,
  output hash_loop_pkg::phase_t phase,
  output logic                  read_ack,
  output logic                  mul_ack,
  output logic                  ram_rden,
  output logic                  ram_wren,
  output logic                  sts_running,
  output logic                  sts_finished
);

  hash_loop_pkg::phase_t phase_next;
  logic                  start_ok;
  logic                  in_read;
  logic                  last_loop;
  logic                  last_write;
  // bit k is high in multiply cycle k
  logic [mult_latency:0] mul_dly;
  logic [iter_log2-1:0]  iter_cnt;

  // start only counts in idle
  assign start_ok = ctrl_start && (phase == hash_loop_pkg::phase_idle);

  assign in_read = (phase == hash_loop_pkg::phase_read1) ||
                   (phase == hash_loop_pkg::phase_read2);

  // rden in the first read cycle, ack in the second
  assign ram_rden = in_read && !read_ack;
  assign ram_wren = (phase == hash_loop_pkg::phase_write1) ||
                    (phase == hash_loop_pkg::phase_write2);

  // product lands mult_latency cycles into the multiply phase
  assign mul_ack = mul_dly[mult_latency];

  assign last_loop = &iter_cnt;
  assign last_write = (phase == hash_loop_pkg::phase_write2) && last_loop;

  // ==========================================================================
  // phase transitions
  // ==========================================================================
  always_comb begin
    phase_next = phase;
    case (phase)
      hash_loop_pkg::phase_idle: begin
        if (start_ok) begin
          phase_next = hash_loop_pkg::phase_read1;
        end
      end
      hash_loop_pkg::phase_read1: begin
        if (read_ack) begin
          phase_next = hash_loop_pkg::phase_cipher;
        end
      end
      hash_loop_pkg::phase_cipher: begin
        phase_next = hash_loop_pkg::phase_write1;
      end
      hash_loop_pkg::phase_write1: begin
        phase_next = hash_loop_pkg::phase_read2;
      end
      hash_loop_pkg::phase_read2: begin
        if (read_ack) begin
          phase_next = hash_loop_pkg::phase_step;
        end
      end
      hash_loop_pkg::phase_step: begin
        phase_next = hash_loop_pkg::phase_mul;
      end
      hash_loop_pkg::phase_mul: begin
        if (mul_ack) begin
          phase_next = hash_loop_pkg::phase_write2;
        end
      end
      hash_loop_pkg::phase_write2: begin
        // back to idle after the last iteration
        if (last_loop) begin
          phase_next = hash_loop_pkg::phase_idle;
        end else begin
          phase_next = hash_loop_pkg::phase_read1;
        end
      end
      default: begin
        phase_next = hash_loop_pkg::phase_idle;
      end
    endcase
  end

  // ==========================================================================
  // state, acks, iteration count and status
  // ==========================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase <= hash_loop_pkg::phase_idle;
      read_ack <= 1'b0;
      mul_dly <= '0;
      iter_cnt <= '0;
      sts_running <= 1'b0;
      sts_finished <= 1'b0;
    end else begin
      phase <= phase_next;
      read_ack <= ram_rden;
      mul_dly <= {mul_dly[mult_latency-1:0], phase == hash_loop_pkg::phase_step};

      // completed iterations, wraps to zero after the last
      if (start_ok) begin
        iter_cnt <= '0;
      end else if (phase == hash_loop_pkg::phase_write2) begin
        iter_cnt <= iter_cnt + 1'b1;
      end

      if (start_ok) begin
        sts_running <= 1'b1;
      end else if (last_write) begin
        sts_running <= 1'b0;
      end
      sts_finished <= last_write;
    end
  end

endmodule

// File: source/lane_shuffle.sv
`timescale 1ns/1ps

module lane_shuffle (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     read_ack,
  input  hash_loop_pkg::lane_idx_t lane_idx,
  input  hash_loop_pkg::line_t     ram_rddata,
  output hash_loop_pkg::lane_set_t rd_lanes,
  input  hash_loop_pkg::lane_set_t wr_lanes,
  input  hash_loop_pkg::phase_t    phase,
  output hash_loop_pkg::line_t     ram_wrdata
);

  // logical lanes in order cx, chk1, chk2, chk3
  hash_loop_pkg::block_t rd_lane [4];
  hash_loop_pkg::block_t wr_lane [4];
  hash_loop_pkg::line_t  wr_line;
  logic                  load_wr;

  // ==========================================================================
  // permutation, logical lane k lives in slot k ^ lane_idx
  // ==========================================================================
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      rd_lane[k] = ram_rddata[128 * (k ^ int'(lane_idx)) +: 128];
    end
  end

  assign wr_lane[0] = wr_lanes.cx;
  assign wr_lane[1] = wr_lanes.chk1;
  assign wr_lane[2] = wr_lanes.chk2;
  assign wr_lane[3] = wr_lanes.chk3;

  // slot 0 is bits [127:0]
  always_comb begin
    for (int s = 0; s < 4; s++) begin
      wr_line[128 * s +: 128] = wr_lane[hash_loop_pkg::lane_idx_t'(s) ^ lane_idx];
    end
  end

  // cipher comes right before write1, the last mul cycle right before write2
  assign load_wr = (phase == hash_loop_pkg::phase_cipher) ||
                   (phase == hash_loop_pkg::phase_mul);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_lanes <= '0;
      ram_wrdata <= '0;
    end else begin
      if (read_ack) begin
        rd_lanes <= {rd_lane[0], rd_lane[1], rd_lane[2], rd_lane[3]};
      end
      if (load_wr) begin
        ram_wrdata <= wr_line;
      end
    end
  end

endmodule

// File: source/mix_datapath.sv
`timescale 1ns/1ps

module mix_datapath #(
  parameter int addr_width = hash_loop_pkg::ADDR_WIDTH_DEFAULT
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       ctrl_start,
  input  hash_loop_pkg::loop_state_t init_state,
  input  hash_loop_pkg::phase_t      phase,
  input  logic                       mul_ack,
  input  hash_loop_pkg::lane_set_t   rd_lanes,
  output hash_loop_pkg::lane_set_t   wr_lanes,
  output logic [addr_width-1:0]      ram_addr,
  output hash_loop_pkg::lane_idx_t   lane_idx,
  output hash_loop_pkg::block_t      cipher_state_in,
  output hash_loop_pkg::block_t      cipher_round_key,
  input  hash_loop_pkg::block_t      cipher_state_out,
  output hash_loop_pkg::word_t       mul_a,
  output hash_loop_pkg::word_t       mul_b,
  input  hash_loop_pkg::word_t       mul_hi,
  input  hash_loop_pkg::word_t       mul_lo,
  output hash_loop_pkg::loop_state_t final_state
);

  hash_loop_pkg::loop_state_t st;
  hash_loop_pkg::block_t      cx;
  hash_loop_pkg::word_t       cl;
  hash_loop_pkg::word_t       ch;
  hash_loop_pkg::block_t      cx_next;
  hash_loop_pkg::block_t      a_mul;
  hash_loop_pkg::word_t       addr_src;
  logic                       second_half;

  // two independent 64-bit sums
  function automatic hash_loop_pkg::block_t add_lanes(hash_loop_pkg::block_t x,
                                                      hash_loop_pkg::block_t y);
    hash_loop_pkg::block_t sum;
    sum.hi = x.hi + y.hi;
    sum.lo = x.lo + y.lo;
    return sum;
  endfunction

  function automatic hash_loop_pkg::block_t byte_rev(hash_loop_pkg::block_t x);
    hash_loop_pkg::block_t r;
    for (int i = 0; i < 16; i++) begin
      r[8 * i +: 8] = x[8 * (15 - i) +: 8];
    end
    return r;
  endfunction

  // ==========================================================================
  // addressing
  // ==========================================================================
  assign second_half = phase inside {hash_loop_pkg::phase_read2, hash_loop_pkg::phase_step,
                                     hash_loop_pkg::phase_mul, hash_loop_pkg::phase_write2};

  // p1 from a.lo, p2 from cx.lo
  assign addr_src = second_half ? cx.lo : st.a.lo;
  assign ram_addr = addr_src[addr_width+5:6];
  assign lane_idx = addr_src[5:4];

  // ==========================================================================
  // cipher, multiply and write-back values
  // ==========================================================================
  assign cipher_state_in = rd_lanes.cx;
  assign cipher_round_key = byte_rev(st.a);
  assign cx_next = cipher_state_out ^ rd_lanes.chk1 ^ rd_lanes.chk2 ^ rd_lanes.chk3;

  assign mul_a = cx.lo;
  assign mul_b = cl;

  // step increment of a folded in here, so a keeps its step value until the product
  assign a_mul.hi = st.a.hi + 64'd1 + mul_lo;
  assign a_mul.lo = st.a.lo + 64'd1 + mul_hi;

  always_comb begin
    wr_lanes.chk1 = add_lanes(rd_lanes.chk1, st.bx0);
    wr_lanes.chk2 = add_lanes(rd_lanes.chk2, st.a);
    wr_lanes.chk3 = add_lanes(rd_lanes.chk3, st.bx1);
    if (phase == hash_loop_pkg::phase_mul) begin
      wr_lanes.cx = a_mul;
    end else begin
      wr_lanes.cx = cx_next ^ st.bx0;
    end
  end

  assign final_state = st;

  // ==========================================================================
  // state registers
  // ==========================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      st <= '0;
      cx <= '0;
      cl <= '0;
      ch <= '0;
    end else begin
      if (ctrl_start && (phase == hash_loop_pkg::phase_idle)) begin
        st <= init_state;
      end else if (mul_ack) begin
        st.a <= a_mul;
      end else if (phase == hash_loop_pkg::phase_write2) begin
        // chain into the next iteration
        st.a <= {st.a.hi ^ ch, st.a.lo ^ cl};
        st.bx1 <= st.bx0;
        st.bx0 <= cx ^ rd_lanes.chk1 ^ rd_lanes.chk2 ^ rd_lanes.chk3;
      end

      if (phase == hash_loop_pkg::phase_cipher) begin
        cx <= cx_next;
      end

      // d is the cx lane of the second line
      if (phase == hash_loop_pkg::phase_step) begin
        cl <= rd_lanes.cx.lo + 64'd1;
        ch <= rd_lanes.cx.hi;
      end
    end
  end

endmodule

// File: source/mul64_pipe.sv
`timescale 1ns/1ps

module mul64_pipe #(
  parameter int mult_latency = hash_loop_pkg::MULT_LATENCY_DEFAULT
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  hash_loop_pkg::word_t mul_a,
  input  hash_loop_pkg::word_t mul_b,
  output hash_loop_pkg::word_t mul_hi,
  output hash_loop_pkg::word_t mul_lo
);

  // product register chain, one new pair per cycle
  logic [127:0] stage [mult_latency];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < mult_latency; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= mul_a * mul_b;
      for (int i = 1; i < mult_latency; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign {mul_hi, mul_lo} = stage[mult_latency-1];

endmodule

// File: source/hash_loop_top.sv
`timescale 1ns/1ps

module hash_loop_top #(
  parameter int addr_width = hash_loop_pkg::ADDR_WIDTH_DEFAULT,
  parameter int iter_log2 = hash_loop_pkg::ITER_LOG2_DEFAULT,
  parameter int mult_latency = hash_loop_pkg::MULT_LATENCY_DEFAULT
) (
  input  logic                       clk,
  input  logic                       reset_n,

  // control and status
  input  logic                       ctrl_start,
  input  hash_loop_pkg::loop_state_t init_state,
  output hash_loop_pkg::loop_state_t final_state,
  output logic                       sts_running,
  output logic                       sts_finished,

  // scratchpad RAM, read data one cycle after ram_rden
  output logic                       ram_rden,
  output logic                       ram_wren,
  output logic [addr_width-1:0]      ram_addr,
  output hash_loop_pkg::line_t       ram_wrdata,
  input  hash_loop_pkg::line_t       ram_rddata,

  // external cipher round
  output hash_loop_pkg::block_t      cipher_state_in,
  output hash_loop_pkg::block_t      cipher_round_key,
  input  hash_loop_pkg::block_t      cipher_state_out
);

  hash_loop_pkg::phase_t    phase;
  logic                     read_ack;
  logic                     mul_ack;
  hash_loop_pkg::lane_idx_t lane_idx;
  hash_loop_pkg::lane_set_t rd_lanes;
  hash_loop_pkg::lane_set_t wr_lanes;
  hash_loop_pkg::word_t     mul_a;
  hash_loop_pkg::word_t     mul_b;
  hash_loop_pkg::word_t     mul_hi;
  hash_loop_pkg::word_t     mul_lo;

  loop_sequencer #(
    .iter_log2    (iter_log2),
    .mult_latency (mult_latency)
  ) u_sequencer (
    .clk          (clk),
    .reset_n      (reset_n),
    .ctrl_start   (ctrl_start),
    .phase        (phase),
    .read_ack     (read_ack),
    .mul_ack      (mul_ack),
    .ram_rden     (ram_rden),
    .ram_wren     (ram_wren),
    .sts_running  (sts_running),
    .sts_finished (sts_finished)
  );

  lane_shuffle u_shuffle (
    .clk        (clk),
    .reset_n    (reset_n),
    .read_ack   (read_ack),
    .lane_idx   (lane_idx),
    .ram_rddata (ram_rddata),
    .rd_lanes   (rd_lanes),
    .wr_lanes   (wr_lanes),
    .phase      (phase),
    .ram_wrdata (ram_wrdata)
  );

  mix_datapath #(
    .addr_width (addr_width)
  ) u_datapath (
    .clk              (clk),
    .reset_n          (reset_n),
    .ctrl_start       (ctrl_start),
    .init_state       (init_state),
    .phase            (phase),
    .mul_ack          (mul_ack),
    .rd_lanes         (rd_lanes),
    .wr_lanes         (wr_lanes),
    .ram_addr         (ram_addr),
    .lane_idx         (lane_idx),
    .cipher_state_in  (cipher_state_in),
    .cipher_round_key (cipher_round_key),
    .cipher_state_out (cipher_state_out),
    .mul_a            (mul_a),
    .mul_b            (mul_b),
    .mul_hi           (mul_hi),
    .mul_lo           (mul_lo),
    .final_state      (final_state)
  );

  mul64_pipe #(
    .mult_latency (mult_latency)
  ) u_mul (
    .clk     (clk),
    .reset_n (reset_n),
    .mul_a   (mul_a),
    .mul_b   (mul_b),
    .mul_hi  (mul_hi),
    .mul_lo  (mul_lo)
  );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns = 20,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset held low for a few rising edges
  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

// File: include/hash_loop_model.svh
`ifndef HASH_LOOP_MODEL_SVH
`define HASH_LOOP_MODEL_SVH

// ============================================================================
// loop reference model, sized by addr_width and iter_log2 of the includer
// ============================================================================
hash_loop_pkg::line_t       model_mem [1 << addr_width];
logic [addr_width-1:0]      exp_addr_q [$];
hash_loop_pkg::line_t       exp_line_q [$];
hash_loop_pkg::loop_state_t model_final;

// two separate 64-bit sums, no carry between halves
function automatic hash_loop_pkg::block_t add_halves(hash_loop_pkg::block_t x,
                                                     hash_loop_pkg::block_t y);
  hash_loop_pkg::block_t s;
  s.hi = x.hi + y.hi;
  s.lo = x.lo + y.lo;
  return s;
endfunction

function automatic hash_loop_pkg::block_t reverse_bytes(hash_loop_pkg::block_t x);
  hash_loop_pkg::block_t r;
  for (int j = 0; j < 16; j++) begin
    r[127 - 8 * j -: 8] = x[8 * j +: 8];
  end
  return r;
endfunction

// cipher stand-in: state mixed with the key rotated left by one byte
function automatic hash_loop_pkg::block_t cipher_mix(hash_loop_pkg::block_t state,
                                                     hash_loop_pkg::block_t key);
  return state ^ {key[119:0], key[127:120]};
endfunction

// logical lane k is found in slot k ^ idx
function automatic hash_loop_pkg::lane_set_t unpack_line(hash_loop_pkg::line_t line,
                                                         hash_loop_pkg::lane_idx_t idx);
  hash_loop_pkg::lane_set_t ls;
  ls.cx   = line[128 * int'(idx) +: 128];
  ls.chk1 = line[128 * (int'(idx) ^ 1) +: 128];
  ls.chk2 = line[128 * (int'(idx) ^ 2) +: 128];
  ls.chk3 = line[128 * (int'(idx) ^ 3) +: 128];
  return ls;
endfunction

function automatic hash_loop_pkg::line_t pack_line(hash_loop_pkg::lane_set_t ls,
                                                   hash_loop_pkg::lane_idx_t idx);
  hash_loop_pkg::line_t line;
  line[128 * int'(idx) +: 128] = ls.cx;
  line[128 * (int'(idx) ^ 1) +: 128] = ls.chk1;
  line[128 * (int'(idx) ^ 2) +: 128] = ls.chk2;
  line[128 * (int'(idx) ^ 3) +: 128] = ls.chk3;
  return line;
endfunction

// runs the whole loop on model_mem and queues every expected write
task automatic predict_run(input hash_loop_pkg::loop_state_t init);
  hash_loop_pkg::block_t    a;
  hash_loop_pkg::block_t    a_old;
  hash_loop_pkg::block_t    bx0;
  hash_loop_pkg::block_t    bx1;
  hash_loop_pkg::block_t    cx;
  hash_loop_pkg::lane_set_t rd;
  hash_loop_pkg::lane_set_t wr;
  hash_loop_pkg::word_t     cl;
  hash_loop_pkg::word_t     ch;
  logic [127:0]             prod;
  logic [addr_width-1:0]    p;
  hash_loop_pkg::lane_idx_t idx;
  exp_addr_q.delete();
  exp_line_q.delete();
  a = init.a;
  bx0 = init.bx0;
  bx1 = init.bx1;
  for (int it = 0; it < (1 << iter_log2); it++) begin
    // cipher half on the line picked by a.lo
    p = a.lo[addr_width+5:6];
    idx = a.lo[5:4];
    rd = unpack_line(model_mem[p], idx);
    cx = cipher_mix(rd.cx, reverse_bytes(a)) ^ rd.chk1 ^ rd.chk2 ^ rd.chk3;
    wr.cx = cx ^ bx0;
    wr.chk1 = add_halves(rd.chk1, bx0);
    wr.chk2 = add_halves(rd.chk2, a);
    wr.chk3 = add_halves(rd.chk3, bx1);
    model_mem[p] = pack_line(wr, idx);
    exp_addr_q.push_back(p);
    exp_line_q.push_back(model_mem[p]);

    // multiply half on the line picked by cx.lo
    p = cx.lo[addr_width+5:6];
    idx = cx.lo[5:4];
    rd = unpack_line(model_mem[p], idx);
    cl = rd.cx.lo + 64'd1;
    ch = rd.cx.hi;
    a_old = a;
    a.hi = a.hi + 64'd1;
    a.lo = a.lo + 64'd1;
    prod = {64'd0, cx.lo} * {64'd0, cl};
    a.lo = a.lo + prod[127:64];
    a.hi = a.hi + prod[63:0];
    wr.cx = a;
    wr.chk1 = add_halves(rd.chk1, bx0);
    wr.chk2 = add_halves(rd.chk2, a_old);
    wr.chk3 = add_halves(rd.chk3, bx1);
    model_mem[p] = pack_line(wr, idx);
    exp_addr_q.push_back(p);
    exp_line_q.push_back(model_mem[p]);

    a = {a.hi ^ ch, a.lo ^ cl};
    bx1 = bx0;
    bx0 = cx ^ rd.chk1 ^ rd.chk2 ^ rd.chk3;
  end
  model_final = {a, bx0, bx1};
endtask

`endif

// File: testbench/hash_loop_tb.sv
`timescale 1ns/1ps

module hash_loop_tb;

  localparam int addr_width = 6;
  localparam int iter_log2 = 3;
  localparam int mult_latency = 2;
  localparam int num_runs = 6;
  localparam int writes_per_run = 2 << iter_log2;
  // six runs of 8 iterations at 11 cycles, doubled, plus slack
  localparam int timeout_cycles = num_runs * (1 << iter_log2) * (mult_latency + 9) * 2 + 50;

  `include "hash_loop_model.svh"

  typedef struct packed {
    hash_loop_pkg::loop_state_t init;
    hash_loop_pkg::loop_state_t restart_state;
    logic [7:0]                 restart_delay;
    logic [7:0]                 exp_writes;
    hash_loop_pkg::loop_state_t exp_final;
  } run_entry_t;

  logic                       clk;
  logic                       reset_n;
  logic                       ctrl_start;
  hash_loop_pkg::loop_state_t init_state;
  hash_loop_pkg::loop_state_t final_state;
  logic                       sts_running;
  logic                       sts_finished;
  logic                       ram_rden;
  logic                       ram_wren;
  logic [addr_width-1:0]      ram_addr;
  hash_loop_pkg::line_t       ram_wrdata;
  hash_loop_pkg::line_t       ram_rddata = '0;
  hash_loop_pkg::block_t      cipher_state_in;
  hash_loop_pkg::block_t      cipher_round_key;
  hash_loop_pkg::block_t      cipher_state_out;

  hash_loop_pkg::line_t ram [1 << addr_width];
  run_entry_t           runs [num_runs];
  integer               seed;
  int                   run_idx = 0;
  int                   write_cnt = 0;
  int                   finish_cnt = 0;
  int                   cycle_cnt = 0;
  logic                 run_open = 1'b0;
  logic                 finish_due = 1'b0;

  tb_clock_gen #(
    .period_ns    (20),
    .reset_cycles (3)
  ) clock_gen0 (
    .clk     (clk),
    .reset_n (reset_n)
  );

  hash_loop_top #(
    .addr_width   (addr_width),
    .iter_log2    (iter_log2),
    .mult_latency (mult_latency)
  ) dut0 (
    .clk              (clk),
    .reset_n          (reset_n),
    .ctrl_start       (ctrl_start),
    .init_state       (init_state),
    .final_state      (final_state),
    .sts_running      (sts_running),
    .sts_finished     (sts_finished),
    .ram_rden         (ram_rden),
    .ram_wren         (ram_wren),
    .ram_addr         (ram_addr),
    .ram_wrdata       (ram_wrdata),
    .ram_rddata       (ram_rddata),
    .cipher_state_in  (cipher_state_in),
    .cipher_round_key (cipher_round_key),
    .cipher_state_out (cipher_state_out)
  );

  // ==========================================================================
  // RAM and cipher models
  // ==========================================================================
  always @(posedge clk) begin
    if (ram_rden) begin
      ram_rddata <= ram[ram_addr];
    end
    if (ram_wren) begin
      ram[ram_addr] <= ram_wrdata;
    end
  end

  assign cipher_state_out = cipher_mix(cipher_state_in, cipher_round_key);

  // ==========================================================================
  // helpers
  // ==========================================================================
  task automatic abort_sim();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] expected);
    if (got !== expected) begin
      $display("FAIL %s got %0h expected %0h", name, got, expected);
      abort_sim();
    end
  endtask

  function automatic hash_loop_pkg::block_t rand_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < (1 << addr_width); i++) begin
      ram[i] = {rand_block(), rand_block(), rand_block(), rand_block()};
      model_mem[i] = ram[i];
    end
  endtask

  // odd runs get a second start strobe in the middle of the run
  task automatic build_table();
    for (int i = 0; i < num_runs; i++) begin
      runs[i].init = {rand_block(), rand_block(), rand_block()};
      runs[i].restart_state = {rand_block(), rand_block(), rand_block()};
      runs[i].restart_delay = (i % 2 == 1) ? 8'(5 + 14 * i) : 8'd0;
      runs[i].exp_writes = 8'(writes_per_run);
      runs[i].exp_final = '0;
    end
  endtask

  // ==========================================================================
  // output monitor sampled on the falling edge
  // ==========================================================================
  always @(negedge clk) begin
    logic exp_running;
    logic exp_finished;
    if (reset_n) begin
      exp_running = run_open && (write_cnt < int'(runs[run_idx].exp_writes));
      exp_finished = finish_due;
      finish_due = 1'b0;
      check_value("sts_running", 512'(sts_running), 512'(exp_running));
      check_value("sts_finished", 512'(sts_finished), 512'(exp_finished));
      if (!exp_running) begin
        check_value("ram_rden", 512'(ram_rden), 512'(1'b0));
        check_value("ram_wren", 512'(ram_wren), 512'(1'b0));
      end
      if (ram_wren) begin
        if (exp_addr_q.size() == 0) begin
          $display("write seen with no expected write left in the stream");
          abort_sim();
        end else begin
          check_value("ram_addr", 512'(ram_addr), 512'(exp_addr_q[0]));
          check_value("ram_wrdata", ram_wrdata, exp_line_q[0]);
          void'(exp_addr_q.pop_front());
          void'(exp_line_q.pop_front());
          write_cnt++;
          finish_due = (write_cnt == int'(runs[run_idx].exp_writes));
        end
      end
      if (sts_finished) begin
        check_value("final_state", 512'(final_state), 512'(runs[run_idx].exp_final));
        finish_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_cycles) begin
      $display("timeout, the DUT did not finish within %0d cycles", timeout_cycles);
      abort_sim();
    end
  end

  // ==========================================================================
  // run table
  // ==========================================================================
  initial begin
    ctrl_start = 1'b0;
    init_state = '0;
    seed = 32'he7d6_87d5;
    fill_memory();
    build_table();
    @(posedge reset_n);
    // a few idle cycles so the monitor sees the reset state
    repeat (4) @(posedge clk);

    for (int r = 0; r < num_runs; r++) begin
      predict_run(runs[r].init);
      runs[r].exp_final = model_final;
      run_idx = r;
      @(posedge clk);
      ctrl_start <= 1'b1;
      init_state <= runs[r].init;
      @(posedge clk);
      ctrl_start <= 1'b0;
      init_state <= runs[r].restart_state;
      write_cnt = 0;
      finish_cnt = 0;
      run_open = 1'b1;
      if (runs[r].restart_delay != 8'd0) begin
        repeat (int'(runs[r].restart_delay)) @(posedge clk);
        ctrl_start <= 1'b1;
        @(posedge clk);
        ctrl_start <= 1'b0;
      end
      while (finish_cnt == 0) begin
        @(posedge clk);
      end
      repeat (3) @(posedge clk);
      for (int i = 0; i < (1 << addr_width); i++) begin
        check_value($sformatf("ram line %0d", i), ram[i], model_mem[i]);
      end
      run_open = 1'b0;
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
source/hash_loop_pkg.sv
source/loop_sequencer.sv
source/lane_shuffle.sv
source/mix_datapath.sv
source/mul64_pipe.sv
source/hash_loop_top.sv
testbench/tb_clock_gen.sv
testbench/hash_loop_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= hash_loop_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv testbench/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -x "Test passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
